//--- include/mem_defines.svh
/*
 * Data cache geometry and address field widths for the memory stage.
 * Included by the package, the cache modules and the testbench.
 * 64 direct-mapped sets of 16-byte lines on a 64-bit address.
 */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// set index and byte offset within a line
`define DC_INDEX_W  6
`define DC_OFFSET_W 4

// whatever is left of the 64-bit address
`define DC_TAG_W    (64 - `DC_INDEX_W - `DC_OFFSET_W)

`define DC_SETS     (1 << `DC_INDEX_W)

// one line moves in a single 128-bit bus beat
`define DC_LINE_W   128

`endif

//--- rtl/mem_pkg.sv
/*
 * Shared types of the memory stage: the 3-bit memory operation code
 * and the cache view of an address. Referenced by scoped names only.
 */
`include "mem_defines.svh"

package mem_pkg;

    // bits 1..0 give the access size for loads and stores alike
    typedef enum logic [2:0] {
        MEM_LW  = 3'b000,
        MEM_LB  = 3'b001,
        MEM_LH  = 3'b010,
        MEM_LD  = 3'b011,
        MEM_LWU = 3'b100,
        MEM_LBU = 3'b101,
        MEM_LHU = 3'b110,
        MEM_INV = 3'b111  // reads as zero
    } mem_op_e;

    typedef struct packed {
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_INDEX_W-1:0] index;
        logic                   word_sel;  // upper or lower half of the line
        logic [2:0]             byte_off;
    } dc_addr_fields_t;

    // raw for the bus, fields for the lookup
    typedef union packed {
        logic [63:0]     raw;
        dc_addr_fields_t f;
    } dc_addr_u;

endpackage

//--- rtl/store_align.sv
/*
 * Store alignment. Moves the low 1, 2, 4 or 8 bytes of the store data
 * up to the byte offset inside the 64-bit word and builds the byte mask.
 * Bytes that would cross the word boundary are dropped.
 */
`timescale 1ns/100ps

module store_align (
    input  mem_pkg::mem_op_e mem_op_i,
    input  logic [2:0]       byte_off_i,
    input  logic [63:0]      wdata_i,
    output logic [63:0]      st_data_o,
    output logic [7:0]       st_mask_o
);

    logic [63:0] sized_data;
    logic [7:0]  size_mask;

    always_comb begin
        case (mem_op_i[1:0])
            2'b01: begin  // byte
                size_mask  = 8'h01;
                sized_data = {56'd0, wdata_i[7:0]};
            end
            2'b10: begin  // half
                size_mask  = 8'h03;
                sized_data = {48'd0, wdata_i[15:0]};
            end
            2'b00: begin  // word
                size_mask  = 8'h0f;
                sized_data = {32'd0, wdata_i[31:0]};
            end
            default: begin  // double
                size_mask  = 8'hff;
                sized_data = wdata_i;
            end
        endcase
    end

    // shifting past bit 63 drops the crossing bytes
    assign st_data_o = sized_data << {byte_off_i, 3'b000};
    assign st_mask_o = size_mask << byte_off_i;

endmodule

//--- rtl/load_align.sv
/*
 * Load alignment. Shifts the selected 64-bit word down by the byte
 * offset, keeps the size of the operation and sign- or zero-extends it.
 * The invalid code returns zero.
 */
`timescale 1ns/100ps

module load_align (
    input  mem_pkg::mem_op_e mem_op_i,
    input  logic [2:0]       byte_off_i,
    input  logic [63:0]      word_i,
    output logic [63:0]      rdata_o
);

    logic [63:0] shifted;

    assign shifted = word_i >> {byte_off_i, 3'b000};

    always_comb begin
        case (mem_op_i)
            mem_pkg::MEM_LW: begin
                rdata_o = {{32{shifted[31]}}, shifted[31:0]};
            end
            mem_pkg::MEM_LB: begin
                rdata_o = {{56{shifted[7]}}, shifted[7:0]};
            end
            mem_pkg::MEM_LH: begin
                rdata_o = {{48{shifted[15]}}, shifted[15:0]};
            end
            mem_pkg::MEM_LD: begin
                rdata_o = shifted;  // full word, nothing to extend
            end
            mem_pkg::MEM_LWU: begin
                rdata_o = {32'd0, shifted[31:0]};
            end
            mem_pkg::MEM_LBU: begin
                rdata_o = {56'd0, shifted[7:0]};
            end
            mem_pkg::MEM_LHU: begin
                rdata_o = {48'd0, shifted[15:0]};
            end
            default: begin
                rdata_o = 64'd0;
            end
        endcase
    end

endmodule

//--- rtl/dcache_array.sv
/*
 * Storage of the direct-mapped data cache: valid, dirty, tag and line
 * arrays indexed by the set field of the address. Reads are
 * combinational; a word write merges masked bytes into one half of the
 * line and a fill replaces the whole line.
 */
`timescale 1ns/100ps
`include "mem_defines.svh"

module dcache_array (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_pkg::dc_addr_u      addr_i,
    input  logic                   word_we_i,
    input  logic [63:0]            st_data_i,
    input  logic [7:0]             st_mask_i,
    input  logic                   fill_we_i,
    input  logic [`DC_LINE_W-1:0]  fill_line_i,
    output logic                   hit_o,
    output logic                   dirty_o,
    output logic [`DC_TAG_W-1:0]   victim_tag_o,
    output logic [`DC_LINE_W-1:0]  victim_line_o,
    output logic [63:0]            rd_word_o
);

    logic [`DC_SETS-1:0]   valid_q;
    logic [`DC_SETS-1:0]   dirty_q;
    logic [`DC_TAG_W-1:0]  tag_mem  [`DC_SETS];
    logic [`DC_LINE_W-1:0] data_mem [`DC_SETS];

    logic [`DC_INDEX_W-1:0] idx;
    logic [`DC_LINE_W-1:0]  cur_line;
    logic [63:0]            merged_word;

    assign idx      = addr_i.f.index;
    assign cur_line = data_mem[idx];

    assign hit_o         = valid_q[idx] && (tag_mem[idx] == addr_i.f.tag);
    assign dirty_o       = valid_q[idx] && dirty_q[idx];
    assign victim_tag_o  = tag_mem[idx];
    assign victim_line_o = cur_line;
    assign rd_word_o     = addr_i.f.word_sel ? cur_line[127:64] : cur_line[63:0];

    // byte merge of the store into the selected half
    always_comb begin
        merged_word = rd_word_o;
        for (int b = 0; b < 8; b++) begin
            if (st_mask_i[b]) begin
                merged_word[b*8 +: 8] = st_data_i[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we_i) begin
            data_mem[idx] <= fill_line_i;
            tag_mem[idx]  <= addr_i.f.tag;
        end else if (word_we_i) begin
            if (addr_i.f.word_sel) begin
                data_mem[idx] <= {merged_word, cur_line[63:0]};
            end else begin
                data_mem[idx] <= {cur_line[127:64], merged_word};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_we_i) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;  // fresh line from memory
        end else if (word_we_i) begin
            dirty_q[idx] <= 1'b1;
        end
    end

endmodule

//--- rtl/dcache_ctrl.sv
/*
 * Data cache controller. Steps through lookup, write-back of a dirty
 * victim, refill and the response cycle, drives the 128-bit memory bus
 * and produces the busy level for the pipeline. A hit answers in the
 * cycle after the lookup edge.
 */
`timescale 1ns/100ps
`include "mem_defines.svh"

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   vis_mem_i,
    input  logic                   req_rw_i,
    input  mem_pkg::dc_addr_u      addr_i,
    input  logic                   hit_i,
    input  logic                   dirty_i,
    input  logic [`DC_TAG_W-1:0]   victim_tag_i,
    input  logic [`DC_LINE_W-1:0]  victim_line_i,
    output logic                   word_we_o,
    output logic                   fill_we_o,
    output logic [`DC_LINE_W-1:0]  fill_line_o,
    output logic                   cpu_ready_o,
    output logic                   m_busy_o,
    output logic [63:0]            d_rw_addr_o,
    output logic                   d_rw_req_o,
    output logic                   d_rw_valid_o,
    output logic [`DC_LINE_W-1:0]  d_rw_w_data_o,
    input  logic [`DC_LINE_W-1:0]  d_data_read_i,
    input  logic                   d_rw_ready_i
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_LOOKUP = 3'd1;
    localparam logic [2:0] S_WBACK  = 3'd2;
    localparam logic [2:0] S_REFILL = 3'd3;
    localparam logic [2:0] S_RESP   = 3'd4;

    logic [2:0]  state_q;
    logic [2:0]  state_d;
    logic [63:0] victim_addr;
    logic [63:0] refill_addr;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (vis_mem_i) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (hit_i) begin
                    state_d = S_RESP;
                end else if (dirty_i) begin
                    state_d = S_WBACK;
                end else begin
                    state_d = S_REFILL;
                end
            end
            S_WBACK: begin
                if (d_rw_ready_i) begin
                    state_d = S_REFILL;
                end
            end
            S_REFILL: begin
                if (d_rw_ready_i) begin
                    state_d = S_RESP;
                end
            end
            default: begin
                state_d = S_IDLE;  // one idle cycle after each response
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // victim line lives at its old tag with the same index
    assign victim_addr = {victim_tag_i, addr_i.f.index, {`DC_OFFSET_W{1'b0}}};
    assign refill_addr = {addr_i.raw[63:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};

    // bus outputs come straight off the state, so they hold under back-pressure
    assign d_rw_valid_o  = (state_q == S_WBACK) || (state_q == S_REFILL);
    assign d_rw_req_o    = (state_q == S_WBACK);
    assign d_rw_addr_o   = (state_q == S_WBACK) ? victim_addr : refill_addr;
    assign d_rw_w_data_o = victim_line_i;

    assign fill_we_o   = (state_q == S_REFILL) && d_rw_ready_i;
    assign fill_line_o = d_data_read_i;  // sampled in the ready cycle

    assign cpu_ready_o = (state_q == S_RESP);
    assign word_we_o   = cpu_ready_o && req_rw_i;  // store lands at the ready edge
    assign m_busy_o    = vis_mem_i && !cpu_ready_o;

endmodule

//--- rtl/mem_stage.sv
/*
 * Memory-access stage of the 64-bit core. Aligns store data, extracts
 * load results and runs every access through the write-back data cache
 * on the 128-bit memory bus. m_busy_o stalls the pipeline until the
 * cache answers.
 */
`timescale 1ns/100ps
`include "mem_defines.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   vis_mem_i,
    input  logic                   req_rw_i,   // 1 = store
    input  mem_pkg::mem_op_e       mem_op_i,
    input  logic [63:0]            addr_i,
    input  logic [63:0]            wdata_i,
    output logic [63:0]            rdata_o,
    output logic                   m_busy_o,
    output logic [63:0]            d_rw_addr_o,
    output logic                   d_rw_req_o,
    output logic                   d_rw_valid_o,
    output logic [`DC_LINE_W-1:0]  d_rw_w_data_o,
    input  logic [`DC_LINE_W-1:0]  d_data_read_i,
    input  logic                   d_rw_ready_i
);

    logic [63:0]            st_data;
    logic [7:0]             st_mask;
    logic                   word_we;
    logic                   fill_we;
    logic [`DC_LINE_W-1:0]  fill_line;
    logic                   hit;
    logic                   dirty;
    logic [`DC_TAG_W-1:0]   victim_tag;
    logic [`DC_LINE_W-1:0]  victim_line;
    logic [63:0]            rd_word;

    store_align i_store_align (
        .mem_op_i   (mem_op_i),
        .byte_off_i (addr_i[2:0]),
        .wdata_i    (wdata_i),
        .st_data_o  (st_data),
        .st_mask_o  (st_mask)
    );

    load_align i_load_align (
        .mem_op_i   (mem_op_i),
        .byte_off_i (addr_i[2:0]),
        .word_i     (rd_word),
        .rdata_o    (rdata_o)
    );

    dcache_ctrl i_dcache_ctrl (
        .clk           (clk),
        .rst           (rst),
        .vis_mem_i     (vis_mem_i),
        .req_rw_i      (req_rw_i),
        .addr_i        (addr_i),
        .hit_i         (hit),
        .dirty_i       (dirty),
        .victim_tag_i  (victim_tag),
        .victim_line_i (victim_line),
        .word_we_o     (word_we),
        .fill_we_o     (fill_we),
        .fill_line_o   (fill_line),
        .cpu_ready_o   (),
        .m_busy_o      (m_busy_o),
        .d_rw_addr_o   (d_rw_addr_o),
        .d_rw_req_o    (d_rw_req_o),
        .d_rw_valid_o  (d_rw_valid_o),
        .d_rw_w_data_o (d_rw_w_data_o),
        .d_data_read_i (d_data_read_i),
        .d_rw_ready_i  (d_rw_ready_i)
    );

    dcache_array i_dcache_array (
        .clk           (clk),
        .rst           (rst),
        .addr_i        (addr_i),
        .word_we_i     (word_we),
        .st_data_i     (st_data),
        .st_mask_i     (st_mask),
        .fill_we_i     (fill_we),
        .fill_line_i   (fill_line),
        .hit_o         (hit),
        .dirty_o       (dirty),
        .victim_tag_o  (victim_tag),
        .victim_line_o (victim_line),
        .rd_word_o     (rd_word)
    );

endmodule

//--- verification/mem_stage_checker.sv
/*
 * Protocol assertions for the memory stage, bound into mem_stage.
 * Watches the memory bus request and the busy level to the pipeline.
 */
`timescale 1ns/100ps

module mem_stage_checker (
    input logic        clk,
    input logic        rst,
    input logic        vis_mem_i,
    input logic        m_busy_o,
    input logic        d_rw_valid_o,
    input logic        d_rw_req_o,
    input logic [63:0] d_rw_addr_o,
    input logic        d_rw_ready_i
);

    // request holds until the memory answers
    bus_hold: assert property (@(posedge clk) disable iff (rst)
        d_rw_valid_o && !d_rw_ready_i |=>
            d_rw_valid_o && $stable(d_rw_addr_o) && $stable(d_rw_req_o))
        else $error("bus request changed before d_rw_ready_i");

    no_busy_idle: assert property (@(posedge clk) disable iff (rst) !vis_mem_i |-> !m_busy_o)
        else $error("m_busy_o high without a request");

    valid_after_rst: assert property (@(posedge clk) rst |=> !d_rw_valid_o)
        else $error("d_rw_valid_o high in the cycle after reset");

endmodule

bind mem_stage mem_stage_checker i_mem_stage_checker (
    .clk          (clk),
    .rst          (rst),
    .vis_mem_i    (vis_mem_i),
    .m_busy_o     (m_busy_o),
    .d_rw_valid_o (d_rw_valid_o),
    .d_rw_req_o   (d_rw_req_o),
    .d_rw_addr_o  (d_rw_addr_o),
    .d_rw_ready_i (d_rw_ready_i)
);

//--- verification/mem_stage_tb.sv
/*
 * Testbench of the memory stage. Applies a table of loads and stores,
 * answers the 128-bit bus from a line memory with random latency and
 * checks load data against a byte-wide reference of memory.
 */
`timescale 1ns/100ps
`include "mem_defines.svh"

module mem_stage_tb;

    localparam logic LOAD  = 1'b0;
    localparam logic STORE = 1'b1;
    localparam logic MISS  = 1'b0;
    localparam logic HIT   = 1'b1;
    localparam logic CLEAN = 1'b0;
    localparam logic WB    = 1'b1;  // dirty victim goes out first

    typedef struct packed {
        logic             st;
        mem_pkg::mem_op_e op;       // stores take their size from bits 1..0
        logic [63:0]      addr;
        logic [63:0]      wdata;
        logic             exp_hit;
        logic             exp_wb;
    } row_t;

    logic clk = 1'b0;
    logic rst;
    logic vis_mem_i;
    logic req_rw_i;
    mem_pkg::mem_op_e mem_op_i;
    logic [63:0] addr_i;
    logic [63:0] wdata_i;
    logic [63:0] rdata_o;
    logic m_busy_o;
    logic [63:0] d_rw_addr_o;
    logic d_rw_req_o;
    logic d_rw_valid_o;
    logic [`DC_LINE_W-1:0] d_rw_w_data_o;
    logic [`DC_LINE_W-1:0] d_data_read_i;
    logic d_rw_ready_i;

    logic [`DC_LINE_W-1:0] mem_lines [4096];  // 64 KiB behind the bus
    logic [7:0] ref_mem [65536];
    row_t tbl [$];
    int rd_beats;
    int wr_beats;
    int n_checks = 0;
    int n_errors = 0;
    int row_idx = 0;
    int cycle_cnt = 0;
    int max_cycles = 0;

    mem_stage i_mem_stage (.*);

    always #10 clk = ~clk;

    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        return a[7:0] ^ a[15:8] ^ 8'ha5;
    endfunction

    function automatic int access_bytes(input logic [2:0] op);
        case (op[1:0])
            2'b01: return 1;
            2'b10: return 2;
            2'b00: return 4;
            default: return 8;
        endcase
    endfunction

    // bytes past the end of the 64-bit word read as zero
    function automatic logic [63:0] expected_load(input logic [2:0] op, input logic [63:0] addr);
        logic [63:0] v;
        int off;
        int nbytes;
        v = '0;
        off = int'(addr[2:0]);
        nbytes = access_bytes(op);
        if (op == 3'b111) begin
            return '0;
        end
        for (int k = 0; k < 8 - off; k++) begin
            v[k*8 +: 8] = ref_mem[addr[15:0] + 16'(k)];
        end
        for (int k = nbytes * 8; k < 64; k++) begin
            v[k] = op[2] ? 1'b0 : v[nbytes*8 - 1];
        end
        return v;
    endfunction

    task automatic store_ref(input logic [2:0] op, input logic [63:0] addr, input logic [63:0] d);
        int off;
        int nbytes;
        off = int'(addr[2:0]);
        nbytes = access_bytes(op);
        for (int k = 0; k < nbytes && off + k < 8; k++) begin
            ref_mem[addr[15:0] + 16'(k)] = d[k*8 +: 8];
        end
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED %s: got %h, expected %h (row %0d)", name, got, exp, row_idx);
        end
    endtask

    task automatic add_row(input logic st, input mem_pkg::mem_op_e op, input logic [63:0] addr,
                           input logic [63:0] wdata, input logic exp_hit, input logic exp_wb);
        tbl.push_back('{st, op, addr, wdata, exp_hit, exp_wb});
    endtask

    task automatic apply_row(input row_t r);
        int busy_cycles;
        int rd0;
        int wr0;
        busy_cycles = 0;
        rd0 = rd_beats;
        wr0 = wr_beats;
        vis_mem_i = 1'b1;
        req_rw_i  = r.st;
        mem_op_i  = r.op;
        addr_i    = r.addr;
        wdata_i   = r.wdata;
        @(negedge clk);
        while (m_busy_o) begin
            busy_cycles++;
            @(negedge clk);
        end
        // store lands at the edge after this response cycle
        if (r.st) begin
            store_ref(r.op, r.addr, r.wdata);
        end else begin
            compare_value("rdata_o", rdata_o, expected_load(r.op, r.addr));
        end
        if (r.exp_hit) begin
            compare_value("m_busy_o cycles", 64'(busy_cycles), 64'd1);
        end
        compare_value("d_rw_valid_o read beats", 64'(rd_beats - rd0), 64'(!r.exp_hit));
        compare_value("d_rw_valid_o write beats", 64'(wr_beats - wr0), 64'(r.exp_wb));
        @(negedge clk);
        vis_mem_i = 1'b0;
        @(negedge clk);
    endtask

    // line memory on the bus answering after 1 to 4 cycles
    initial begin : memory_model
        logic [15:0] ba;
        int wait_cnt;
        logic pending;
        void'($urandom(68));
        d_rw_ready_i  = 1'b0;
        d_data_read_i = '0;
        rd_beats = 0;
        wr_beats = 0;
        pending  = 1'b0;
        wait_cnt = 0;
        for (int a = 0; a < 65536; a++) begin
            ba = 16'(a);
            mem_lines[ba[15:4]][{ba[3:0], 3'b000} +: 8] = fill_byte(ba);
        end
        forever begin
            @(negedge clk);
            if (d_rw_ready_i) begin
                d_rw_ready_i = 1'b0;
                pending = 1'b0;
            end
            if (d_rw_valid_o === 1'b1 && !pending) begin
                pending  = 1'b1;
                wait_cnt = $urandom % 4;
            end
            if (pending) begin
                if (wait_cnt == 0) begin
                    if (d_rw_req_o) begin
                        mem_lines[d_rw_addr_o[15:`DC_OFFSET_W]] = d_rw_w_data_o;
                        wr_beats++;
                    end else begin
                        d_data_read_i = mem_lines[d_rw_addr_o[15:`DC_OFFSET_W]];
                        rd_beats++;
                    end
                    d_rw_ready_i = 1'b1;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: the DUT stopped answering after %0d cycles", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        vis_mem_i = 1'b0;
        req_rw_i  = 1'b0;
        mem_op_i  = mem_pkg::MEM_LD;
        addr_i    = '0;
        wdata_i   = '0;
        for (int a = 0; a < 65536; a++) begin
            ref_mem[16'(a)] = fill_byte(16'(a));
        end
        add_row(LOAD,  mem_pkg::MEM_LB,  64'h0040, 64'h0, MISS, CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LBU, 64'h0043, 64'h0, HIT,  CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LH,  64'h0046, 64'h0, HIT,  CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LHU, 64'h0042, 64'h0, HIT,  CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LW,  64'h004c, 64'h0, HIT,  CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LWU, 64'h0048, 64'h0, HIT,  CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LD,  64'h0040, 64'h0, HIT,  CLEAN);
        add_row(LOAD,  mem_pkg::MEM_INV, 64'h0044, 64'h0, HIT,  CLEAN);
        // each load size at every offset that stays inside its word
        for (int op = 0; op < 7; op++) begin
            for (int off = 0; off < 16; off++) begin
                if ((off % 8) + access_bytes(3'(op)) <= 8) begin
                    add_row(LOAD, mem_pkg::mem_op_e'(op), 64'h0040 + 64'(off), 64'h0,
                            HIT, CLEAN);
                end
            end
        end
        add_row(LOAD,  mem_pkg::MEM_LB,  64'h0087, 64'h0, MISS, CLEAN);  // positive bytes
        add_row(LOAD,  mem_pkg::MEM_LH,  64'h008a, 64'h0, HIT,  CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LW,  64'h0084, 64'h0, HIT,  CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LBU, 64'h008d, 64'h0, HIT,  CLEAN);
        add_row(STORE, mem_pkg::MEM_LB,  64'h0041, 64'h7f, HIT, CLEAN);
        add_row(STORE, mem_pkg::MEM_LH,  64'h0046, 64'h8001, HIT, CLEAN);
        add_row(STORE, mem_pkg::MEM_LW,  64'h004c, 64'hdeadbeef, HIT, CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LD,  64'h0040, 64'h0, HIT,  CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LD,  64'h0048, 64'h0, HIT,  CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LH,  64'h0046, 64'h0, HIT,  CLEAN);
        add_row(STORE, mem_pkg::MEM_LD,  64'h0120, 64'h0123456789abcdef, MISS, CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LW,  64'h0124, 64'h0, HIT,  CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LD,  64'h0440, 64'h0, MISS, WB);  // evicts dirty 0x0040
        add_row(LOAD,  mem_pkg::MEM_LD,  64'h0040, 64'h0, MISS, CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LW,  64'h004c, 64'h0, HIT,  CLEAN);
        add_row(STORE, mem_pkg::MEM_LB,  64'h0525, 64'h5a, MISS, WB);
        add_row(LOAD,  mem_pkg::MEM_LD,  64'h0120, 64'h0, MISS, WB);
        add_row(STORE, mem_pkg::MEM_LW,  64'h0086, 64'h11223344, HIT, CLEAN);  // crosses word
        add_row(LOAD,  mem_pkg::MEM_LD,  64'h0080, 64'h0, HIT,  CLEAN);
        add_row(LOAD,  mem_pkg::MEM_LD,  64'h0088, 64'h0, HIT,  CLEAN);
        max_cycles = tbl.size() * 20;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare_value("m_busy_o", 64'(m_busy_o), 64'd0);
        compare_value("d_rw_valid_o", 64'(d_rw_valid_o), 64'd0);
        foreach (tbl[i]) begin
            row_idx = i;
            apply_row(tbl[i]);
        end
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- mem_stage.f
+incdir+include
rtl/mem_pkg.sv
rtl/store_align.sv
rtl/load_align.sv
rtl/dcache_array.sv
rtl/dcache_ctrl.sv
rtl/mem_stage.sv
verification/mem_stage_checker.sv
verification/mem_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := mem_stage_tb
FILELIST  := mem_stage.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
